// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_sram
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; \
	else echo "Simulation passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
src/amba_pkg.sv
src/sysbus_pkg.sv
src/axi_slv.sv
src/sram_dev.sv
src/axi_sram_top.sv
sim/axi_sram_assert.sv
sim/tb_axi_sram.sv

// ==== sim/axi_sram_assert.sv ====
`timescale 1ns/1ps

module axi_sram_assert (
    input logic                   i_clk,
    input logic                   i_nrst,
    input amba_pkg::axi_slv_in_t  i_axi,
    input amba_pkg::axi_slv_out_t o_axi,
    input sysbus_pkg::sys_req_t   o_req,
    input logic                   i_req_ready
);

    // An offered R or B beat stays until the master takes it
    r_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_axi.r_valid && !i_axi.r_ready |=> o_axi.r_valid)
        else $error("R valid dropped before R ready");

    b_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_axi.b_valid && !i_axi.b_ready |=> o_axi.b_valid)
        else $error("B valid dropped before B ready");

    // Request payload frozen while the SRAM stalls
    req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req.valid && !i_req_ready |=> o_req.valid && $stable(o_req))
        else $error("Request changed while stalled");

    // R last only rides on a valid beat
    r_last_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_axi.r_last |-> o_axi.r_valid)
        else $error("R last high without R valid");

    reset_idle: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> !o_axi.r_valid && !o_axi.b_valid && !o_req.valid)
        else $error("Valid high right after reset");

endmodule

bind axi_slv axi_sram_assert asrt0 (
    .i_clk       (i_clk),
    .i_nrst      (i_nrst),
    .i_axi       (i_axi),
    .o_axi       (o_axi),
    .o_req       (o_req),
    .i_req_ready (i_req_ready)
);

// ==== sim/tb_axi_sram.sv ====
`timescale 1ns/1ps

module tb_axi_sram;

    import amba_pkg::*;
    import sysbus_pkg::*;

    localparam axi_addr_t   BASE    = 32'h4000_0000;
    localparam logic [31:0] SEED    = 32'h26be_256a;
    localparam int          TIMEOUT = 200;

    logic         clk;
    logic         nrst;
    mapinfo_t     mapinfo;
    axi_slv_in_t  axi_in;
    axi_slv_out_t axi_out;

    logic [31:0] rng;
    logic [7:0]  model [SRAM_BYTES];
    // R and B ready are high when a random value mod 4 is below this
    int          ready_odds;

    axi_sram_top dut0 (
        .i_clk     (clk),
        .i_nrst    (nrst),
        .i_mapinfo (mapinfo),
        .i_axi     (axi_in),
        .o_axi     (axi_out)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic tick_timeout(inout int cnt, input string what);
        cnt++;
        if (cnt > TIMEOUT) begin
            $display("Timeout while waiting for %s", what);
            $display("=== FAIL ===");
            $fatal(1, "wait limit reached");
        end
    endtask

    // Byte offset of beat i, from the AXI burst address rules
    function automatic int beat_addr(int start, int beats, int bytes, axi_burst_t burst, int i);
        int block;
        int base;
        block = beats * bytes;
        base = start - start % block;
        case (burst)
            AXI_BURST_FIXED: return start;
            AXI_BURST_WRAP:  return base + (start - base + i * bytes) % block;
            default:         return start + i * bytes;
        endcase
    endfunction

    function automatic logic [3:0] lane_strb(int off, int bytes);
        case (bytes)
            1:       return 4'(4'b0001 << (off % 4));
            2:       return 4'(4'b0011 << (off % 4));
            default: return 4'hf;
        endcase
    endfunction

    task automatic model_write(int off, logic [31:0] data, logic [3:0] strb);
        int word;
        word = off - off % 4;
        if (off < SRAM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    model[word + i] = data[8*i +: 8];
                end
            end
        end
    endtask

    function automatic logic [31:0] model_read(int off);
        int word;
        logic [31:0] w;
        word = off - off % 4;
        w = '0;
        if (off < SRAM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                w[8*i +: 8] = model[word + i];
            end
        end
        return w;
    endfunction

    function automatic axi_ax_t make_ax(logic [3:0] id, int off, int beats, int size,
                                        axi_burst_t burst);
        axi_ax_t ax;
        ax.valid = 1'b1;
        ax.id = id;
        ax.addr = BASE + axi_addr_t'(off);
        ax.len = axi_len_t'(beats - 1);
        ax.size = axi_size_t'(size);
        ax.burst = burst;
        return ax;
    endfunction

    task automatic send_aw(logic [3:0] id, int off, int beats, int size, axi_burst_t burst);
        int cnt;
        cnt = 0;
        @(posedge clk);
        axi_in.aw <= make_ax(id, off, beats, size, burst);
        @(negedge clk);
        while (!axi_out.aw_ready) begin
            tick_timeout(cnt, "AW ready");
            @(negedge clk);
        end
        @(posedge clk);
        axi_in.aw.valid <= 1'b0;
    endtask

    task automatic send_ar(logic [3:0] id, int off, int beats, int size, axi_burst_t burst);
        int cnt;
        cnt = 0;
        @(posedge clk);
        axi_in.ar <= make_ax(id, off, beats, size, burst);
        @(negedge clk);
        while (!axi_out.ar_ready) begin
            tick_timeout(cnt, "AR ready");
            @(negedge clk);
        end
        @(posedge clk);
        axi_in.ar.valid <= 1'b0;
    endtask

    // W beats in order, the model follows each accepted beat
    task automatic send_w(int off, int beats, int size, axi_burst_t burst, logic rand_strb,
                          output logic exp_err);
        int cnt;
        int a;
        int bytes;
        logic [31:0] data;
        logic [3:0] strb;
        bytes = 1 << size;
        exp_err = 1'b0;
        for (int k = 0; k < beats; k++) begin
            a = beat_addr(off, beats, bytes, burst, k);
            data = next_rand();
            strb = lane_strb(a, bytes);
            if (rand_strb) begin
                strb = strb & 4'(next_rand());
            end
            @(posedge clk);
            axi_in.w.valid <= 1'b1;
            axi_in.w.data <= data;
            axi_in.w.strb <= strb;
            axi_in.w.last <= (k == beats - 1);
            cnt = 0;
            @(negedge clk);
            while (!axi_out.w_ready) begin
                tick_timeout(cnt, "W ready");
                @(negedge clk);
            end
            model_write(a, data, strb);
            exp_err = exp_err | (a >= SRAM_BYTES);
        end
        @(posedge clk);
        axi_in.w.valid <= 1'b0;
    endtask

    task automatic recv_b(string name, logic [3:0] id, logic exp_err);
        int cnt;
        cnt = 0;
        forever begin
            @(posedge clk);
            axi_in.b_ready <= (next_rand() % 4) < ready_odds;
            @(negedge clk);
            if (axi_out.b_valid && axi_in.b_ready) begin
                break;
            end
            tick_timeout(cnt, "B response");
        end
        check_val({name, " b_id"}, 32'(id), 32'(axi_out.b_id));
        check_val({name, " b_resp"}, exp_err ? 32'(AXI_RESP_SLVERR) : 32'(AXI_RESP_OKAY),
                  32'(axi_out.b_resp));
    endtask

    task automatic recv_r(string name, logic [3:0] id, int off, int beats, int size,
                          axi_burst_t burst);
        int cnt;
        int k;
        int a;
        logic sticky;
        cnt = 0;
        k = 0;
        sticky = 1'b0;
        while (k < beats) begin
            @(posedge clk);
            axi_in.r_ready <= (next_rand() % 4) < ready_odds;
            @(negedge clk);
            if (axi_out.r_valid && axi_in.r_ready) begin
                a = beat_addr(off, beats, 1 << size, burst, k);
                sticky = sticky | (a >= SRAM_BYTES);
                check_val($sformatf("%s data beat %0d", name, k), model_read(a), axi_out.r_data);
                check_val($sformatf("%s last beat %0d", name, k), 32'(k == beats - 1),
                          32'(axi_out.r_last));
                check_val({name, " r_id"}, 32'(id), 32'(axi_out.r_id));
                check_val({name, " r_resp"},
                          sticky ? 32'(AXI_RESP_SLVERR) : 32'(AXI_RESP_OKAY),
                          32'(axi_out.r_resp));
                k++;
                cnt = 0;
            end else begin
                tick_timeout(cnt, "R beat");
            end
        end
    endtask

    task automatic write_burst(string name, logic [3:0] id, int off, int beats, int size,
                               axi_burst_t burst, logic rand_strb);
        logic exp_err;
        send_aw(id, off, beats, size, burst);
        send_w(off, beats, size, burst, rand_strb, exp_err);
        recv_b(name, id, exp_err);
    endtask

    task automatic read_burst(string name, logic [3:0] id, int off, int beats, int size,
                              axi_burst_t burst);
        send_ar(id, off, beats, size, burst);
        recv_r(name, id, off, beats, size, burst);
    endtask

    // AR and AW on one edge, the write must land before the read
    task automatic write_read_same(int off, logic [3:0] id);
        int cnt;
        logic exp_err;
        cnt = 0;
        @(posedge clk);
        axi_in.aw <= make_ax(id, off, 1, 2, AXI_BURST_INCR);
        axi_in.ar <= make_ax(id, off, 1, 2, AXI_BURST_INCR);
        @(negedge clk);
        while (!(axi_out.aw_ready && axi_out.ar_ready)) begin
            tick_timeout(cnt, "AW and AR ready");
            @(negedge clk);
        end
        @(posedge clk);
        axi_in.aw.valid <= 1'b0;
        axi_in.ar.valid <= 1'b0;
        send_w(off, 1, 2, AXI_BURST_INCR, 1'b0, exp_err);
        recv_b("tie write", id, exp_err);
        recv_r("tie read", id, off, 1, 2, AXI_BURST_INCR);
    endtask

    initial begin
        int off;
        int beats;
        int size;
        int bytes;
        logic [3:0] id;
        clk = 1'b0;
        nrst = 1'b0;
        mapinfo.addr_start = BASE;
        mapinfo.addr_end = BASE + axi_addr_t'(SRAM_BYTES - 1);
        axi_in = '0;
        rng = SEED;
        ready_odds = 3;
        for (int i = 0; i < SRAM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        nrst <= 1'b1;

        // Give every word a known value first
        for (int i = 0; i < SRAM_BYTES / 64; i++) begin
            write_burst("fill", 4'h0, i * 64, 16, 2, AXI_BURST_INCR, 1'b0);
        end

        repeat (80) begin
            size = int'(next_rand() % 3);
            bytes = 1 << size;
            off = int'(next_rand() % SRAM_BYTES) & ~(bytes - 1);
            id = 4'(next_rand());
            if ((next_rand() & 1) != 0) begin
                write_burst("single write", id, off, 1, size, AXI_BURST_INCR, 1'b1);
            end
            read_burst("single read", id, off, 1, size, AXI_BURST_INCR);
        end

        repeat (30) begin
            size = int'(next_rand() % 3);
            bytes = 1 << size;
            beats = int'(next_rand() % 16) + 1;
            off = int'(next_rand() % (SRAM_BYTES - beats * bytes + 1)) & ~(bytes - 1);
            id = 4'(next_rand());
            write_burst("incr write", id, off, beats, size, AXI_BURST_INCR, 1'b0);
            read_burst("incr read", id, off, beats, size, AXI_BURST_INCR);
        end

        for (int b = 1; b <= 4; b++) begin
            beats = 1 << b;
            repeat (3) begin
                size = int'(next_rand() % 3);
                bytes = 1 << size;
                off = int'(next_rand() % SRAM_BYTES) & ~(bytes - 1);
                id = 4'(next_rand());
                write_burst("wrap write", id, off, beats, size, AXI_BURST_WRAP, 1'b0);
                // Aligned block read in order shows where each beat landed
                read_burst("wrap block", id, off - off % (beats * bytes), beats, size,
                           AXI_BURST_INCR);
                read_burst("wrap read", id, off, beats, size, AXI_BURST_WRAP);
            end
        end

        repeat (4) begin
            off = int'(next_rand() % SRAM_BYTES) & ~3;
            beats = int'(next_rand() % 4) + 2;
            id = 4'(next_rand());
            write_burst("fixed write", id, off, beats, 2, AXI_BURST_FIXED, 1'b0);
            read_burst("fixed read", id, off, 1, 2, AXI_BURST_INCR);
        end

        repeat (8) begin
            beats = int'(next_rand() % 4) + 1;
            off = SRAM_BYTES + (int'(next_rand() % 2048) & ~3);
            id = 4'(next_rand());
            write_burst("oor write", id, off, beats, 2, AXI_BURST_INCR, 1'b1);
            read_burst("oor read", id, off, beats, 2, AXI_BURST_INCR);
            // Same low address bits inside the window stay untouched
            read_burst("oor alias", id, off % SRAM_BYTES, 1, 2, AXI_BURST_INCR);
        end

        // Mostly stalled R and B
        ready_odds = 1;
        for (int i = 0; i < SRAM_BYTES / 64; i++) begin
            read_burst("slow read", 4'(i), i * 64, 16, 2, AXI_BURST_INCR);
        end
        repeat (10) begin
            beats = int'(next_rand() % 16) + 1;
            off = int'(next_rand() % (SRAM_BYTES - beats * 4 + 1)) & ~3;
            id = 4'(next_rand());
            write_burst("slow write", id, off, beats, 2, AXI_BURST_INCR, 1'b1);
            read_burst("slow readback", id, off, beats, 2, AXI_BURST_INCR);
        end
        ready_odds = 3;

        repeat (8) begin
            write_read_same(int'(next_rand() % SRAM_BYTES) & ~3, 4'(next_rand()));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== src/amba_pkg.sv ====
package amba_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_resp_t;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_t;

    localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
    localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

    // Address channel, same layout for AR and AW
    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        logic      valid;
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    // Everything the master drives into the slave
    typedef struct packed {
        axi_ax_t ar;
        axi_ax_t aw;
        axi_w_t  w;
        logic    r_ready;
        logic    b_ready;
    } axi_slv_in_t;

    typedef struct packed {
        logic      ar_ready;
        logic      aw_ready;
        logic      w_ready;
        logic      r_valid;
        axi_id_t   r_id;
        axi_data_t r_data;
        axi_resp_t r_resp;
        logic      r_last;
        logic      b_valid;
        axi_id_t   b_id;
        axi_resp_t b_resp;
    } axi_slv_out_t;

endpackage

// ==== src/axi_slv.sv ====
`timescale 1ns/1ps

module axi_slv (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  sysbus_pkg::mapinfo_t   i_mapinfo,
    input  amba_pkg::axi_slv_in_t  i_axi,
    output amba_pkg::axi_slv_out_t o_axi,
    output sysbus_pkg::sys_req_t   o_req,
    input  logic                   i_req_ready,
    input  sysbus_pkg::sys_resp_t  i_resp
);

    import amba_pkg::*;
    import sysbus_pkg::*;

    typedef enum logic [2:0] {
        R_IDLE, R_ADDR, R_DATA, R_LAST, R_BUF, R_WAIT_WRITE
    } rstate_t;

    typedef enum logic [2:0] {
        W_IDLE, W_REQ, W_PIPE, W_BUF, W_RESP, W_WAIT_READ, W_B
    } wstate_t;

    typedef struct packed {
        rstate_t    rstate;
        wstate_t    wstate;
        logic       ar_ready;
        logic       aw_ready;
        logic       w_ready;
        sys_req_t   req;
        // Read burst context, ar_addr is the address of the current beat
        axi_id_t    ar_id;
        axi_burst_t ar_burst;
        axi_len_t   ar_len;
        axi_len_t   ar_rem;
        sys_bytes_t ar_bytes;
        sys_addr_t  ar_addr;
        logic       ar_err;
        logic       r_valid;
        logic       r_last;
        logic       r_err;
        axi_data_t  r_data;
        logic       rb_last;
        logic       rb_err;
        axi_data_t  rb_data;
        // Write burst context, aw_addr is the address of the next beat to load
        axi_id_t    aw_id;
        axi_burst_t aw_burst;
        axi_len_t   aw_len;
        axi_len_t   aw_rem;
        sys_bytes_t aw_bytes;
        sys_addr_t  aw_addr;
        logic [1:0] w_pend;
        logic       b_valid;
        logic       b_err;
        axi_data_t  wb_data;
        axi_strb_t  wb_strb;
    } regs_t;

    regs_t r;
    regs_t rin;

    function automatic sys_addr_t next_addr(sys_addr_t addr, axi_burst_t burst,
                                            sys_bytes_t bytes, axi_len_t len);
        sys_addr_t inc;
        sys_addr_t mask;
        inc = addr + sys_addr_t'(bytes);
        // Wrap block is beat bytes times beat count
        mask = (sys_addr_t'(len) + 1) * sys_addr_t'(bytes) - 1;
        case (burst)
            AXI_BURST_FIXED: return addr;
            AXI_BURST_WRAP:  return (addr & ~mask) | (inc & mask);
            default:         return inc;
        endcase
    endfunction

    function automatic sys_req_t make_req(logic write, sys_addr_t addr, sys_bytes_t bytes,
                                          sys_data_t data, sys_strb_t strb, logic last);
        sys_req_t q;
        q.valid = 1'b1;
        q.write = write;
        q.addr = addr;
        q.size_bytes = bytes;
        q.wdata = data;
        q.wstrb = strb;
        q.last = last;
        return q;
    endfunction

    always_comb begin
        regs_t v;
        logic read_busy;
        logic w_hs;
        logic w_resp;

        v = r;
        read_busy = (r.rstate != R_IDLE) && (r.rstate != R_WAIT_WRITE);
        w_hs = r.w_ready & i_axi.w.valid;
        // Responses seen while the write owns the port belong to the write
        w_resp = i_resp.valid && (r.wstate inside {W_REQ, W_PIPE, W_BUF, W_RESP});

        if (r.req.valid && i_req_ready) begin
            v.req.valid = 1'b0;
        end
        if (r.r_valid && i_axi.r_ready) begin
            v.r_valid = 1'b0;
            v.r_last = 1'b0;
        end
        if (r.b_valid && i_axi.b_ready) begin
            v.b_valid = 1'b0;
        end
        v.w_pend = r.w_pend + 2'(r.req.valid & i_req_ready & r.req.write) - 2'(w_resp);
        if (w_resp) begin
            v.b_err = r.b_err | i_resp.err;
        end

        // Read channel
        case (r.rstate)
            R_IDLE: begin
                if (r.ar_ready && i_axi.ar.valid) begin
                    v.ar_ready = 1'b0;
                    v.ar_id = i_axi.ar.id;
                    v.ar_burst = i_axi.ar.burst;
                    v.ar_len = i_axi.ar.len;
                    v.ar_rem = i_axi.ar.len;
                    v.ar_bytes = sys_bytes_t'(1 << i_axi.ar.size);
                    v.ar_addr = sys_addr_t'(i_axi.ar.addr - i_mapinfo.addr_start);
                    v.ar_err = 1'b0;
                    // Write has priority on a tie
                    if (r.wstate != W_IDLE || (i_axi.aw.valid && r.aw_ready)) begin
                        v.rstate = R_WAIT_WRITE;
                    end else begin
                        v.req = make_req(1'b0, v.ar_addr, v.ar_bytes, '0, '0, v.ar_rem == '0);
                        v.rstate = R_ADDR;
                    end
                end
            end
            R_WAIT_WRITE: begin
                if (r.wstate == W_IDLE && !(i_axi.aw.valid && r.aw_ready)) begin
                    v.req = make_req(1'b0, r.ar_addr, r.ar_bytes, '0, '0, r.ar_rem == '0);
                    v.rstate = R_ADDR;
                end
            end
            R_ADDR: begin
                if (i_req_ready) begin
                    v.rstate = R_DATA;
                end
            end
            R_DATA: begin
                if (i_resp.valid) begin
                    v.ar_err = r.ar_err | i_resp.err;
                    if (r.r_valid && !i_axi.r_ready) begin
                        // Previous beat still held, park this one
                        v.rb_data = i_resp.rdata;
                        v.rb_err = v.ar_err;
                        v.rb_last = (r.ar_rem == '0);
                        v.rstate = R_BUF;
                    end else begin
                        v.r_valid = 1'b1;
                        v.r_data = i_resp.rdata;
                        v.r_err = v.ar_err;
                        v.r_last = (r.ar_rem == '0);
                        if (r.ar_rem == '0) begin
                            v.rstate = R_LAST;
                        end else begin
                            v.ar_addr = next_addr(r.ar_addr, r.ar_burst, r.ar_bytes, r.ar_len);
                            v.ar_rem = r.ar_rem - 1'b1;
                            v.req = make_req(1'b0, v.ar_addr, r.ar_bytes, '0, '0,
                                             v.ar_rem == '0);
                            v.rstate = R_ADDR;
                        end
                    end
                end
            end
            R_BUF: begin
                if (i_axi.r_ready) begin
                    v.r_valid = 1'b1;
                    v.r_data = r.rb_data;
                    v.r_err = r.rb_err;
                    v.r_last = r.rb_last;
                    if (r.rb_last) begin
                        v.rstate = R_LAST;
                    end else begin
                        v.ar_addr = next_addr(r.ar_addr, r.ar_burst, r.ar_bytes, r.ar_len);
                        v.ar_rem = r.ar_rem - 1'b1;
                        v.req = make_req(1'b0, v.ar_addr, r.ar_bytes, '0, '0, v.ar_rem == '0);
                        v.rstate = R_ADDR;
                    end
                end
            end
            R_LAST: begin
                if (r.r_valid && i_axi.r_ready) begin
                    v.ar_ready = 1'b1;
                    v.rstate = R_IDLE;
                end
            end
            default: v.rstate = R_IDLE;
        endcase

        // Write channel
        case (r.wstate)
            W_IDLE: begin
                if (r.aw_ready && i_axi.aw.valid) begin
                    v.aw_ready = 1'b0;
                    v.aw_id = i_axi.aw.id;
                    v.aw_burst = i_axi.aw.burst;
                    v.aw_len = i_axi.aw.len;
                    v.aw_rem = i_axi.aw.len;
                    v.aw_bytes = sys_bytes_t'(1 << i_axi.aw.size);
                    v.aw_addr = sys_addr_t'(i_axi.aw.addr - i_mapinfo.addr_start);
                    v.b_err = 1'b0;
                    v.w_pend = '0;
                    if (read_busy) begin
                        v.wstate = W_WAIT_READ;
                    end else begin
                        v.w_ready = 1'b1;
                        v.wstate = W_REQ;
                    end
                end
            end
            W_WAIT_READ: begin
                if (!read_busy) begin
                    v.w_ready = 1'b1;
                    v.wstate = W_REQ;
                end
            end
            W_REQ: begin
                if (w_hs) begin
                    v.req = make_req(1'b1, r.aw_addr, r.aw_bytes, i_axi.w.data, i_axi.w.strb,
                                     r.aw_rem == '0);
                    v.aw_addr = next_addr(r.aw_addr, r.aw_burst, r.aw_bytes, r.aw_len);
                    v.aw_rem = r.aw_rem - 1'b1;
                    v.w_ready = (r.aw_rem != '0);
                    v.wstate = W_PIPE;
                end
            end
            W_PIPE: begin
                if (i_req_ready) begin
                    if (r.req.last) begin
                        v.wstate = W_RESP;
                    end else if (w_hs) begin
                        v.req = make_req(1'b1, r.aw_addr, r.aw_bytes, i_axi.w.data,
                                         i_axi.w.strb, r.aw_rem == '0);
                        v.aw_addr = next_addr(r.aw_addr, r.aw_burst, r.aw_bytes, r.aw_len);
                        v.aw_rem = r.aw_rem - 1'b1;
                        v.w_ready = (r.aw_rem != '0);
                    end else begin
                        v.wstate = W_REQ;
                    end
                end else if (w_hs) begin
                    // Port busy, hold the beat here
                    v.wb_data = i_axi.w.data;
                    v.wb_strb = i_axi.w.strb;
                    v.w_ready = 1'b0;
                    v.wstate = W_BUF;
                end
            end
            W_BUF: begin
                if (i_req_ready) begin
                    v.req = make_req(1'b1, r.aw_addr, r.aw_bytes, r.wb_data, r.wb_strb,
                                     r.aw_rem == '0);
                    v.aw_addr = next_addr(r.aw_addr, r.aw_burst, r.aw_bytes, r.aw_len);
                    v.aw_rem = r.aw_rem - 1'b1;
                    v.w_ready = (r.aw_rem != '0);
                    v.wstate = W_PIPE;
                end
            end
            W_RESP: begin
                if (v.w_pend == '0) begin
                    v.b_valid = 1'b1;
                    v.wstate = W_B;
                end
            end
            W_B: begin
                if (r.b_valid && i_axi.b_ready) begin
                    v.aw_ready = 1'b1;
                    v.wstate = W_IDLE;
                end
            end
            default: v.wstate = W_IDLE;
        endcase

        rin = v;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= '0;
            r.ar_ready <= 1'b1;
            r.aw_ready <= 1'b1;
        end else begin
            r <= rin;
        end
    end

    assign o_req = r.req;

    always_comb begin
        o_axi.ar_ready = r.ar_ready;
        o_axi.aw_ready = r.aw_ready;
        o_axi.w_ready = r.w_ready;
        o_axi.r_valid = r.r_valid;
        o_axi.r_id = r.ar_id;
        o_axi.r_data = r.r_data;
        o_axi.r_resp = r.r_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        o_axi.r_last = r.r_last;
        o_axi.b_valid = r.b_valid;
        o_axi.b_id = r.aw_id;
        o_axi.b_resp = r.b_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end

endmodule

// ==== src/axi_sram_top.sv ====
`timescale 1ns/1ps

module axi_sram_top (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  sysbus_pkg::mapinfo_t   i_mapinfo,
    input  amba_pkg::axi_slv_in_t  i_axi,
    output amba_pkg::axi_slv_out_t o_axi
);

    import sysbus_pkg::*;

    sys_req_t  req;
    logic      req_ready;
    sys_resp_t resp;

    // AXI burst to per-beat requests
    axi_slv slv0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_mapinfo   (i_mapinfo),
        .i_axi       (i_axi),
        .o_axi       (o_axi),
        .o_req       (req),
        .i_req_ready (req_ready),
        .i_resp      (resp)
    );

    sram_dev mem0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (req),
        .o_req_ready (req_ready),
        .o_resp      (resp)
    );

endmodule

// ==== src/sram_dev.sv ====
`timescale 1ns/1ps

module sram_dev (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  sysbus_pkg::sys_req_t  i_req,
    output logic                  o_req_ready,
    output sysbus_pkg::sys_resp_t o_resp
);

    import sysbus_pkg::*;

    typedef enum logic {ST_READY, ST_MERGE} state_t;

    state_t    state;
    sys_data_t mem [SRAM_WORDS];
    sram_idx_t idx;
    sram_idx_t m_idx;
    sys_data_t m_wdata;
    sys_strb_t m_wstrb;
    logic      accept;
    logic      in_range;
    logic      partial;
    logic      resp_valid;
    logic      resp_err;
    sys_data_t resp_rdata;

    // Byte lanes with a strobe take the new data
    function automatic sys_data_t merge(sys_data_t old_w, sys_data_t new_w, sys_strb_t strb);
        sys_data_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign o_req_ready = (state == ST_READY);
    assign accept = i_req.valid && o_req_ready;
    assign in_range = (i_req.addr < sys_addr_t'(SRAM_BYTES));
    assign idx = i_req.addr[SRAM_IDX_BITS+1:2];
    assign partial = i_req.write && in_range && (i_req.wstrb != 4'hf);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_READY;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (state == ST_MERGE) begin
                state <= ST_READY;
                resp_valid <= 1'b1;
            end else if (accept) begin
                if (partial) begin
                    state <= ST_MERGE;
                end else begin
                    resp_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            m_idx <= idx;
            m_wdata <= i_req.wdata;
            m_wstrb <= i_req.wstrb;
            resp_err <= !in_range;
            resp_rdata <= '0;
            if (in_range && !i_req.write) begin
                resp_rdata <= mem[idx];
            end
            if (in_range && i_req.write && !partial) begin
                mem[idx] <= i_req.wdata;
            end
        end
        if (state == ST_MERGE) begin
            mem[m_idx] <= merge(mem[m_idx], m_wdata, m_wstrb);
        end
    end

    assign o_resp.valid = resp_valid;
    assign o_resp.rdata = resp_rdata;
    assign o_resp.err = resp_err;

endmodule

// ==== src/sysbus_pkg.sv ====
package sysbus_pkg;

    localparam int SYS_ADDR_BITS = 32;
    localparam int SRAM_WORDS    = 256;
    localparam int SRAM_BYTES    = SRAM_WORDS * 4;
    localparam int SRAM_IDX_BITS = $clog2(SRAM_WORDS);

    typedef logic [SYS_ADDR_BITS-1:0] sys_addr_t;
    typedef logic [31:0]              sys_data_t;
    typedef logic [3:0]               sys_strb_t;
    // Bytes per beat: 1, 2 or 4
    typedef logic [2:0]               sys_bytes_t;
    typedef logic [SRAM_IDX_BITS-1:0] sram_idx_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        sys_addr_t  addr;
        sys_bytes_t size_bytes;
        sys_data_t  wdata;
        sys_strb_t  wstrb;
        logic       last;
    } sys_req_t;

    typedef struct packed {
        logic      valid;
        sys_data_t rdata;
        logic      err;
    } sys_resp_t;

    typedef struct packed {
        logic [31:0] addr_start;
        logic [31:0] addr_end;
    } mapinfo_t;

endpackage
